// File: logic/la_pipe_pkg.sv
`default_nettype none

package la_pipe_pkg;

    localparam int REG_NUM = 32;
    localparam int REG_ADDR_W = $clog2(REG_NUM);

    typedef struct packed {
        logic [31:0] pc;
        logic [31:0] instr;
        logic        valid;
    } instr_info_t;

    typedef struct packed {
        logic        we;
        logic [13:0] addr;
        logic [31:0] data;
    } csr_write_t;

    // for memory-side exceptions wdata carries the faulting virtual address
    typedef struct packed {
        instr_info_t           instr_info;
        logic                  wreg;
        logic [REG_ADDR_W-1:0] waddr;
        logic [31:0]           wdata;
        logic                  ertn;
        csr_write_t            csr_write;
    } mem_wb_t;

    typedef struct packed {
        logic                  we;
        logic [REG_ADDR_W-1:0] waddr;
        logic [31:0]           wdata;
        logic [31:0]           pc;
    } wb_reg_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
        logic [31:0] instr;
    } commit_t;

endpackage

`default_nettype wire

// File: logic/la_excp_pkg.sv
`default_nettype none

package la_excp_pkg;

    localparam int EXCP_NUM_W = 16;
    localparam int EXCP_IDX_W = $clog2(EXCP_NUM_W);

    // fetch-side sources first, then decode, then memory-side sources
    localparam int EXCP_INT    = 0;
    localparam int EXCP_ADEF   = 1;
    localparam int EXCP_TLBR_F = 2;
    localparam int EXCP_PIF    = 3;
    localparam int EXCP_PPI_F  = 4;
    localparam int EXCP_SYS    = 5;
    localparam int EXCP_BRK    = 6;
    localparam int EXCP_INE    = 7;
    localparam int EXCP_IPE    = 8;
    localparam int EXCP_ALE    = 9;
    localparam int EXCP_ADEM   = 10;
    localparam int EXCP_TLBR_M = 11;
    localparam int EXCP_PME    = 12;
    localparam int EXCP_PPI_M  = 13;
    localparam int EXCP_PIS    = 14;
    localparam int EXCP_PIL    = 15;

    localparam logic [5:0] ECODE_INT  = 6'h00;
    localparam logic [5:0] ECODE_PIL  = 6'h01;
    localparam logic [5:0] ECODE_PIS  = 6'h02;
    localparam logic [5:0] ECODE_PIF  = 6'h03;
    localparam logic [5:0] ECODE_PME  = 6'h04;
    localparam logic [5:0] ECODE_PPI  = 6'h07;
    localparam logic [5:0] ECODE_ADE  = 6'h08;
    localparam logic [5:0] ECODE_ALE  = 6'h09;
    localparam logic [5:0] ECODE_SYS  = 6'h0b;
    localparam logic [5:0] ECODE_BRK  = 6'h0c;
    localparam logic [5:0] ECODE_INE  = 6'h0d;
    localparam logic [5:0] ECODE_IPE  = 6'h0e;
    localparam logic [5:0] ECODE_TLBR = 6'h3f;

    localparam logic [8:0] ESUBCODE_ADEF = 9'h000;
    localparam logic [8:0] ESUBCODE_ADEM = 9'h001;

    localparam logic [13:0] CSR_CRMD   = 14'h000;
    localparam logic [13:0] CSR_PRMD   = 14'h001;
    localparam logic [13:0] CSR_ESTAT  = 14'h005;
    localparam logic [13:0] CSR_ERA    = 14'h006;
    localparam logic [13:0] CSR_BADV   = 14'h007;
    localparam logic [13:0] CSR_EENTRY = 14'h00c;
    localparam logic [13:0] CSR_TLBEHI = 14'h011;

    typedef struct packed {
        logic [5:0]  ecode;
        logic [8:0]  esubcode;
        logic        va_error;
        logic [31:0] bad_va;
        logic        tlb_refill;
        logic        tlb;
        logic [18:0] vppn;
    } excp_report_t;

endpackage

`default_nettype wire

// File: logic/mem_wb.sv
`timescale 1ns/1ps
`default_nettype none

module mem_wb (
    input  wire                   clk,
    input  wire                   rst_n_i,
    input  wire                   stall_i,
    input  wire                   flush_i,
    input  wire                   excp_i,
    input  la_pipe_pkg::mem_wb_t  mem_i,
    output la_pipe_pkg::wb_reg_t  wb_reg_o,
    output la_pipe_pkg::csr_write_t wb_csr_o,
    output la_pipe_pkg::commit_t  commit_o
);

    logic kill;

    // an exception or ERTN redirects fetch, so the record itself never commits
    assign kill = flush_i | excp_i | mem_i.ertn;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            wb_reg_o <= '0;
            wb_csr_o <= '0;
            commit_o <= '0;
        end else if (kill) begin
            wb_reg_o <= '0;
            wb_csr_o <= '0;
            commit_o <= '0;
        end else if (stall_i) begin
            // hold the write-back fields, only the commit record drops
            commit_o <= '0;
        end else begin
            wb_reg_o.we    <= mem_i.wreg;
            wb_reg_o.waddr <= mem_i.waddr;
            wb_reg_o.wdata <= mem_i.wdata;
            wb_reg_o.pc    <= mem_i.instr_info.pc;
            wb_csr_o       <= mem_i.csr_write;
            commit_o.valid <= mem_i.instr_info.valid;
            commit_o.pc    <= mem_i.instr_info.pc;
            commit_o.instr <= mem_i.instr_info.instr;
        end
    end

    // a killed record leaves no trace in the write-back stage
    kill_clears_wb: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        kill |=> (!wb_reg_o.we && !wb_csr_o.we && !commit_o.valid)
    ) else $error("mem_wb: killed record reached write-back");

endmodule

`default_nettype wire

// File: logic/excp_encoder.sv
`timescale 1ns/1ps
`default_nettype none

module excp_encoder (
    input  la_pipe_pkg::mem_wb_t                   mem_i,
    input  wire [la_excp_pkg::EXCP_NUM_W-1:0]      excp_num_i,
    output la_excp_pkg::excp_report_t              report_o
);

    logic [la_excp_pkg::EXCP_IDX_W-1:0] idx;
    logic                               hit;
    logic                               from_pc;
    logic                               from_data;
    logic                               is_tlb;
    logic                               is_refill;
    logic [31:0]                        addr;

    // scan from the top so the lowest set bit is the last one assigned
    always_comb begin
        hit = |excp_num_i;
        idx = '0;
        for (int i = la_excp_pkg::EXCP_NUM_W - 1; i >= 0; i--) begin
            if (excp_num_i[i]) begin
                idx = i[la_excp_pkg::EXCP_IDX_W-1:0];
            end
        end
    end

    always_comb begin
        report_o.ecode    = '0;
        report_o.esubcode = '0;
        from_pc   = 1'b0;
        from_data = 1'b0;
        is_tlb    = 1'b0;
        is_refill = 1'b0;
        if (hit) begin
            case (idx)
                la_excp_pkg::EXCP_INT: report_o.ecode = la_excp_pkg::ECODE_INT;
                la_excp_pkg::EXCP_ADEF: begin
                    report_o.ecode    = la_excp_pkg::ECODE_ADE;
                    report_o.esubcode = la_excp_pkg::ESUBCODE_ADEF;
                    from_pc           = 1'b1;
                end
                la_excp_pkg::EXCP_TLBR_F: begin
                    report_o.ecode = la_excp_pkg::ECODE_TLBR;
                    from_pc        = 1'b1;
                    is_tlb         = 1'b1;
                    is_refill      = 1'b1;
                end
                la_excp_pkg::EXCP_PIF: begin
                    report_o.ecode = la_excp_pkg::ECODE_PIF;
                    from_pc        = 1'b1;
                    is_tlb         = 1'b1;
                end
                la_excp_pkg::EXCP_PPI_F: begin
                    report_o.ecode = la_excp_pkg::ECODE_PPI;
                    from_pc        = 1'b1;
                    is_tlb         = 1'b1;
                end
                la_excp_pkg::EXCP_SYS: report_o.ecode = la_excp_pkg::ECODE_SYS;
                la_excp_pkg::EXCP_BRK: report_o.ecode = la_excp_pkg::ECODE_BRK;
                la_excp_pkg::EXCP_INE: report_o.ecode = la_excp_pkg::ECODE_INE;
                la_excp_pkg::EXCP_IPE: report_o.ecode = la_excp_pkg::ECODE_IPE;
                la_excp_pkg::EXCP_ALE: begin
                    report_o.ecode = la_excp_pkg::ECODE_ALE;
                    from_data      = 1'b1;
                end
                la_excp_pkg::EXCP_ADEM: begin
                    report_o.ecode    = la_excp_pkg::ECODE_ADE;
                    report_o.esubcode = la_excp_pkg::ESUBCODE_ADEM;
                    from_data         = 1'b1;
                end
                la_excp_pkg::EXCP_TLBR_M: begin
                    report_o.ecode = la_excp_pkg::ECODE_TLBR;
                    from_data      = 1'b1;
                    is_tlb         = 1'b1;
                    is_refill      = 1'b1;
                end
                la_excp_pkg::EXCP_PME: begin
                    report_o.ecode = la_excp_pkg::ECODE_PME;
                    from_data      = 1'b1;
                    is_tlb         = 1'b1;
                end
                la_excp_pkg::EXCP_PPI_M: begin
                    report_o.ecode = la_excp_pkg::ECODE_PPI;
                    from_data      = 1'b1;
                    is_tlb         = 1'b1;
                end
                la_excp_pkg::EXCP_PIS: begin
                    report_o.ecode = la_excp_pkg::ECODE_PIS;
                    from_data      = 1'b1;
                    is_tlb         = 1'b1;
                end
                default: begin
                    report_o.ecode = la_excp_pkg::ECODE_PIL;
                    from_data      = 1'b1;
                    is_tlb         = 1'b1;
                end
            endcase
        end
    end

    assign addr = from_pc   ? mem_i.instr_info.pc :
                  from_data ? mem_i.wdata : '0;

    assign report_o.va_error   = from_pc | from_data;
    assign report_o.bad_va     = addr;
    assign report_o.tlb_refill = is_refill;
    assign report_o.tlb        = is_tlb;
    assign report_o.vppn       = is_tlb ? addr[31:13] : '0;

endmodule

`default_nettype wire

// File: logic/csr_excp_regs.sv
`timescale 1ns/1ps
`default_nettype none

module csr_excp_regs (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire                        excp_i,
    input  wire                        ertn_i,
    input  wire                        commit_valid_i,
    input  wire [31:0]                 epc_i,
    input  la_excp_pkg::excp_report_t  report_i,
    input  la_pipe_pkg::csr_write_t    csr_wr_i,
    input  wire [13:0]                 csr_raddr_i,
    output logic [31:0]                csr_rdata_o,
    output logic                       redirect_valid_o,
    output logic [31:0]                redirect_pc_o
);

    logic [1:0]  crmd_plv;
    logic        crmd_ie;
    logic [1:0]  prmd_pplv;
    logic        prmd_pie;
    logic [5:0]  estat_ecode;
    logic [8:0]  estat_esubcode;
    logic [31:0] era;
    logic [31:0] badv;
    logic [25:0] eentry_va;
    logic [18:0] tlbehi_vppn;
    logic        csr_we;

    // a stalled write-back slot keeps its CSR write but is not committed again
    assign csr_we = commit_valid_i & csr_wr_i.we;

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            crmd_plv         <= '0;
            crmd_ie          <= 1'b0;
            prmd_pplv        <= '0;
            prmd_pie         <= 1'b0;
            estat_ecode      <= '0;
            estat_esubcode   <= '0;
            era              <= '0;
            badv             <= '0;
            eentry_va        <= '0;
            tlbehi_vppn      <= '0;
            redirect_valid_o <= 1'b0;
            redirect_pc_o    <= '0;
        end else begin
            if (csr_we) begin
                case (csr_wr_i.addr)
                    la_excp_pkg::CSR_CRMD: begin
                        crmd_plv <= csr_wr_i.data[1:0];
                        crmd_ie  <= csr_wr_i.data[2];
                    end
                    la_excp_pkg::CSR_PRMD: begin
                        prmd_pplv <= csr_wr_i.data[1:0];
                        prmd_pie  <= csr_wr_i.data[2];
                    end
                    la_excp_pkg::CSR_ERA:    era         <= csr_wr_i.data;
                    la_excp_pkg::CSR_BADV:   badv        <= csr_wr_i.data;
                    la_excp_pkg::CSR_EENTRY: eentry_va   <= csr_wr_i.data[31:6];
                    la_excp_pkg::CSR_TLBEHI: tlbehi_vppn <= csr_wr_i.data[31:13];
                    default: ;
                endcase
            end
            // the faulting record is younger than the one in write-back, so it wins
            if (excp_i) begin
                era            <= epc_i;
                estat_ecode    <= report_i.ecode;
                estat_esubcode <= report_i.esubcode;
                if (report_i.va_error) begin
                    badv <= report_i.bad_va;
                end
                if (report_i.tlb) begin
                    tlbehi_vppn <= report_i.vppn;
                end
                prmd_pplv <= crmd_plv;
                prmd_pie  <= crmd_ie;
                crmd_plv  <= 2'd0;
                crmd_ie   <= 1'b0;
            end else if (ertn_i) begin
                crmd_plv <= prmd_pplv;
                crmd_ie  <= prmd_pie;
            end
            redirect_valid_o <= excp_i | ertn_i;
            redirect_pc_o    <= excp_i ? {eentry_va, 6'b0} : era;
        end
    end

    always_comb begin
        case (csr_raddr_i)
            la_excp_pkg::CSR_CRMD:   csr_rdata_o = {29'b0, crmd_ie, crmd_plv};
            la_excp_pkg::CSR_PRMD:   csr_rdata_o = {29'b0, prmd_pie, prmd_pplv};
            la_excp_pkg::CSR_ESTAT:  csr_rdata_o = {1'b0, estat_esubcode, estat_ecode, 16'b0};
            la_excp_pkg::CSR_ERA:    csr_rdata_o = era;
            la_excp_pkg::CSR_BADV:   csr_rdata_o = badv;
            la_excp_pkg::CSR_EENTRY: csr_rdata_o = {eentry_va, 6'b0};
            la_excp_pkg::CSR_TLBEHI: csr_rdata_o = {tlbehi_vppn, 13'b0};
            default:                 csr_rdata_o = '0;
        endcase
    end

    // interrupts are sampled outside this stage, so a zero code means an empty vector
    excp_has_code: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        excp_i |-> report_i.ecode != '0
    ) else $error("csr_excp_regs: exception raised without a cause");

endmodule

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/1ps
`default_nettype none

module reg_file (
    input  wire                                 clk,
    input  wire                                 rst_n_i,
    input  la_pipe_pkg::wb_reg_t                wb_i,
    input  wire [la_pipe_pkg::REG_ADDR_W-1:0]   raddr_i,
    output logic [31:0]                         rdata_o
);

    logic [31:0] regs [la_pipe_pkg::REG_NUM];

    // r0 is cleared once at reset and never written afterwards
    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            regs[0] <= '0;
        end else if (wb_i.we && wb_i.waddr != '0) begin
            regs[wb_i.waddr] <= wb_i.wdata;
        end
    end

    assign rdata_o = regs[raddr_i];

    r0_reads_zero: assert property (
        @(posedge clk) disable iff (!rst_n_i)
        raddr_i == '0 |-> rdata_o == '0
    ) else $error("reg_file: register 0 read back nonzero");

endmodule

`default_nettype wire

// File: logic/commit_stage.sv
`timescale 1ns/1ps
`default_nettype none

module commit_stage (
    input  wire                                 clk,
    input  wire                                 rst_n_i,
    input  la_pipe_pkg::mem_wb_t                mem_i,
    input  wire                                 excp_i,
    input  wire [la_excp_pkg::EXCP_NUM_W-1:0]   excp_num_i,
    input  wire                                 stall_i,
    input  wire                                 flush_i,
    input  wire [la_pipe_pkg::REG_ADDR_W-1:0]   rf_raddr_i,
    input  wire [13:0]                          csr_raddr_i,
    output la_pipe_pkg::commit_t                commit_o,
    output logic [31:0]                         rf_rdata_o,
    output logic [31:0]                         csr_rdata_o,
    output logic                                redirect_valid_o,
    output logic [31:0]                         redirect_pc_o
);

    la_pipe_pkg::wb_reg_t      wb_reg;
    la_pipe_pkg::csr_write_t   wb_csr;
    la_excp_pkg::excp_report_t report;

    mem_wb mem_wb_i (
        .clk      (clk),
        .rst_n_i  (rst_n_i),
        .stall_i  (stall_i),
        .flush_i  (flush_i),
        .excp_i   (excp_i),
        .mem_i    (mem_i),
        .wb_reg_o (wb_reg),
        .wb_csr_o (wb_csr),
        .commit_o (commit_o)
    );

    excp_encoder excp_encoder_i (
        .mem_i      (mem_i),
        .excp_num_i (excp_num_i),
        .report_o   (report)
    );

    csr_excp_regs csr_excp_regs_i (
        .clk              (clk),
        .rst_n_i          (rst_n_i),
        .excp_i           (excp_i),
        .ertn_i           (mem_i.ertn),
        .commit_valid_i   (commit_o.valid),
        .epc_i            (mem_i.instr_info.pc),
        .report_i         (report),
        .csr_wr_i         (wb_csr),
        .csr_raddr_i      (csr_raddr_i),
        .csr_rdata_o      (csr_rdata_o),
        .redirect_valid_o (redirect_valid_o),
        .redirect_pc_o    (redirect_pc_o)
    );

    reg_file reg_file_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .wb_i    (wb_reg),
        .raddr_i (rf_raddr_i),
        .rdata_o (rf_rdata_o)
    );

endmodule

`default_nettype wire

// File: dv/clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module clk_gen (
    output logic clk,
    output logic rst_n_o
);

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // reset stays low through four rising edges
    initial begin
        rst_n_o = 1'b0;
        repeat (4) @(posedge clk);
        #1 rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

// File: dv/commit_checker.sv
`timescale 1ns/1ps
`default_nettype none

module commit_checker (
    input  wire                   clk,
    input  la_pipe_pkg::commit_t  commit_i,
    input  wire                   redirect_valid_i,
    input  wire [31:0]            redirect_pc_i,
    input  wire [31:0]            rf_rdata_i,
    input  wire [31:0]            csr_rdata_i,
    input  wire                   start_i,
    input  wire [8*12-1:0]        name_i,
    input  la_pipe_pkg::commit_t  exp_commit_i,
    input  wire                   exp_redirect_i,
    input  wire [31:0]            exp_redirect_pc_i,
    input  wire [1:0]             rd_kind_i,
    input  wire [31:0]            exp_rdata_i,
    output logic                  done_o,
    output int                    test_count_o,
    output int                    fail_count_o
);

    localparam int WAIT_MAX = 8;

    initial begin : check_tests
        int          n;
        int          errors;
        logic        got_commit;
        logic        got_redirect;
        logic [31:0] rdata;
        done_o       = 1'b0;
        test_count_o = 0;
        fail_count_o = 0;
        forever begin
            @(posedge start_i);
            done_o       = 1'b0;
            errors       = 0;
            got_commit   = 1'b0;
            got_redirect = 1'b0;
            // the falling edge sits halfway between two input changes
            for (n = 0; n < WAIT_MAX; n++) begin
                @(negedge clk);
                if (commit_i.valid && !got_commit) begin
                    got_commit = 1'b1;
                    if (!exp_commit_i.valid) begin
                        $display("Fail at %0t: unexpected commit of pc %h", $time, commit_i.pc);
                        errors++;
                    end else if (commit_i.pc != exp_commit_i.pc ||
                                 commit_i.instr != exp_commit_i.instr) begin
                        $display("Fail at %0t: commit pc %h instr %h, expected pc %h instr %h",
                                 $time, commit_i.pc, commit_i.instr,
                                 exp_commit_i.pc, exp_commit_i.instr);
                        errors++;
                    end
                end
                if (redirect_valid_i && !got_redirect) begin
                    got_redirect = 1'b1;
                    if (!exp_redirect_i) begin
                        $display("Fail at %0t: unexpected redirect to %h", $time, redirect_pc_i);
                        errors++;
                    end else if (redirect_pc_i != exp_redirect_pc_i) begin
                        $display("Fail at %0t: redirect to %h, expected %h",
                                 $time, redirect_pc_i, exp_redirect_pc_i);
                        errors++;
                    end
                end
                // writes land two edges after the record, so reads wait at least that long
                if (n >= 2 && (got_commit || !exp_commit_i.valid) &&
                        (got_redirect || !exp_redirect_i)) begin
                    break;
                end
            end
            if (exp_commit_i.valid && !got_commit) begin
                $display("test %0s: the commit did not arrive within %0d cycles", name_i, WAIT_MAX);
                errors++;
            end
            if (exp_redirect_i && !got_redirect) begin
                $display("test %0s: no redirect came within %0d cycles", name_i, WAIT_MAX);
                errors++;
            end
            rdata = (rd_kind_i == 2'd2) ? csr_rdata_i : rf_rdata_i;
            if (rd_kind_i != 2'd0 && rdata != exp_rdata_i) begin
                $display("Fail at %0t: read kind %0d gave %h, expected %h",
                         $time, rd_kind_i, rdata, exp_rdata_i);
                errors++;
            end
            test_count_o = test_count_o + 1;
            if (errors == 0) begin
                $display("test %0s: ok", name_i);
            end else begin
                fail_count_o = fail_count_o + 1;
                $display("test %0s: failed", name_i);
            end
            done_o = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: dv/tb_commit_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_commit_stage;

    localparam int DONE_WAIT  = 16;
    localparam int RESET_WAIT = 20;
    localparam int MAX_LINES  = 256;

    logic                               clk;
    logic                               rst_n;
    la_pipe_pkg::mem_wb_t               mem;
    logic                               excp;
    logic [la_excp_pkg::EXCP_NUM_W-1:0] excp_num;
    logic                               stall;
    logic                               flush;
    logic [la_pipe_pkg::REG_ADDR_W-1:0] rf_raddr;
    logic [13:0]                        csr_raddr;
    la_pipe_pkg::commit_t               commit;
    logic [31:0]                        rf_rdata;
    logic [31:0]                        csr_rdata;
    logic                               redirect_valid;
    logic [31:0]                        redirect_pc;

    logic                               start;
    logic [8*12-1:0]                    name;
    la_pipe_pkg::commit_t               exp_commit;
    logic                               exp_redirect;
    logic [31:0]                        exp_redirect_pc;
    logic [1:0]                         rd_kind;
    logic [31:0]                        exp_rdata;
    logic                               done;
    int                                 test_count;
    int                                 fail_count;

    clk_gen clk_gen_i (
        .clk     (clk),
        .rst_n_o (rst_n)
    );

    commit_stage commit_stage_i (
        .clk              (clk),
        .rst_n_i          (rst_n),
        .mem_i            (mem),
        .excp_i           (excp),
        .excp_num_i       (excp_num),
        .stall_i          (stall),
        .flush_i          (flush),
        .rf_raddr_i       (rf_raddr),
        .csr_raddr_i      (csr_raddr),
        .commit_o         (commit),
        .rf_rdata_o       (rf_rdata),
        .csr_rdata_o      (csr_rdata),
        .redirect_valid_o (redirect_valid),
        .redirect_pc_o    (redirect_pc)
    );

    commit_checker commit_checker_i (
        .clk               (clk),
        .commit_i          (commit),
        .redirect_valid_i  (redirect_valid),
        .redirect_pc_i     (redirect_pc),
        .rf_rdata_i        (rf_rdata),
        .csr_rdata_i       (csr_rdata),
        .start_i           (start),
        .name_i            (name),
        .exp_commit_i      (exp_commit),
        .exp_redirect_i    (exp_redirect),
        .exp_redirect_pc_i (exp_redirect_pc),
        .rd_kind_i         (rd_kind),
        .exp_rdata_i       (exp_rdata),
        .done_o            (done),
        .test_count_o      (test_count),
        .fail_count_o      (fail_count)
    );

    // an idle slot carries no valid record, so it neither writes nor commits
    task automatic drive_idle();
        mem      = '0;
        excp     = 1'b0;
        excp_num = '0;
        stall    = 1'b0;
        flush    = 1'b0;
    endtask

    initial begin : run_tests
        int          fd;
        int          line_no;
        int          n;
        int          fields;
        logic        aborted;
        string       line;
        logic [31:0] s_valid, s_pc, s_instr, s_wreg, s_waddr, s_wdata, s_ertn;
        logic [31:0] s_csr_we, s_csr_addr, s_csr_data, s_excp, s_num, s_stall, s_flush;
        logic [31:0] e_commit, e_redirect, e_redirect_pc, e_rd_kind, e_rd_addr, e_rdata;
        aborted         = 1'b0;
        start           = 1'b0;
        name            = '0;
        exp_commit      = '0;
        exp_redirect    = 1'b0;
        exp_redirect_pc = '0;
        rd_kind         = '0;
        exp_rdata       = '0;
        rf_raddr        = '0;
        csr_raddr       = '0;
        fd              = 0;
        drive_idle();

        n = 0;
        while (rst_n !== 1'b1 && n < RESET_WAIT) begin
            @(posedge clk);
            n++;
        end
        if (rst_n !== 1'b1) begin
            $display("reset was never released");
            aborted = 1'b1;
        end else begin
            fd = $fopen("dv/commit_tests.txt", "r");
            if (fd == 0) begin
                $display("could not open dv/commit_tests.txt");
                aborted = 1'b1;
            end
        end

        line_no = 0;
        while (!aborted && line_no < MAX_LINES && $fgets(line, fd) != 0) begin
            line_no++;
            if (line.len() < 2 || line.getc(0) == "#") begin
                continue;
            end
            fields = $sscanf(line, "%s %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                             name, s_valid, s_pc, s_instr, s_wreg, s_waddr, s_wdata, s_ertn,
                             s_csr_we, s_csr_addr, s_csr_data, s_excp, s_num, s_stall, s_flush,
                             e_commit, e_redirect, e_redirect_pc, e_rd_kind, e_rd_addr, e_rdata);
            if (fields != 21) begin
                $display("line %0d of the test file has %0d fields instead of 21", line_no, fields);
                aborted = 1'b1;
                continue;
            end

            @(posedge clk);
            #1;
            mem.instr_info.valid = s_valid[0];
            mem.instr_info.pc    = s_pc;
            mem.instr_info.instr = s_instr;
            mem.wreg             = s_wreg[0];
            mem.waddr            = s_waddr[la_pipe_pkg::REG_ADDR_W-1:0];
            mem.wdata            = s_wdata;
            mem.ertn             = s_ertn[0];
            mem.csr_write.we     = s_csr_we[0];
            mem.csr_write.addr   = s_csr_addr[13:0];
            mem.csr_write.data   = s_csr_data;
            excp                 = s_excp[0];
            excp_num             = s_num[la_excp_pkg::EXCP_NUM_W-1:0];
            stall                = s_stall[0];
            flush                = s_flush[0];
            rf_raddr             = e_rd_addr[la_pipe_pkg::REG_ADDR_W-1:0];
            csr_raddr            = e_rd_addr[13:0];
            // a committed record reports its own pc and instruction word
            exp_commit.valid     = e_commit[0];
            exp_commit.pc        = s_pc;
            exp_commit.instr     = s_instr;
            exp_redirect         = e_redirect[0];
            exp_redirect_pc      = e_redirect_pc;
            rd_kind              = e_rd_kind[1:0];
            exp_rdata            = e_rdata;
            start                = 1'b1;

            @(posedge clk);
            #1;
            drive_idle();
            n = 0;
            while (!done && n < DONE_WAIT) begin
                @(posedge clk);
                n++;
            end
            start = 1'b0;
            if (!done) begin
                $display("the checker did not finish test %0s", name);
                aborted = 1'b1;
            end
        end
        if (fd != 0) begin
            $fclose(fd);
        end

        $display("tests run: %0d, tests failed: %0d", test_count, fail_count);
        if (!aborted && test_count > 0 && fail_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: commit_stage.f
logic/la_pipe_pkg.sv
logic/la_excp_pkg.sv
logic/mem_wb.sv
logic/excp_encoder.sv
logic/csr_excp_regs.sv
logic/reg_file.sv
logic/commit_stage.sv
dv/clk_gen.sv
dv/commit_checker.sv
dv/tb_commit_stage.sv

// File: Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_commit_stage \
		-f commit_stage.f -Mdir obj_dir
	./obj_dir/Vtb_commit_stage | tee $(LOG)
	@grep -q "All checks passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// File: dv/commit_tests.txt
# name v pc instr wreg waddr wdata ertn csr_we csr_addr csr_data excp excp_num stall flush
# then commit redirect redirect_pc, read kind (0 none 1 reg 2 csr), read address, read data
wr_r5     1 1c000000 02800405 1 05 12345678 0 0 000 00000000 0 0000 0 0 1 0 00000000 1 005 12345678
wr_r0     1 1c000004 02bffc00 1 00 deadbeef 0 0 000 00000000 0 0000 0 0 1 0 00000000 1 000 00000000
stall     1 1c000008 02800805 1 05 aaaa5555 0 0 000 00000000 0 0000 1 0 0 0 00000000 1 005 12345678
unstall   1 1c00000c 02800c05 1 05 0badcafe 0 0 000 00000000 0 0000 0 0 1 0 00000000 1 005 0badcafe
flush     1 1c000010 02801005 1 05 11111111 0 0 000 00000000 0 0000 0 1 0 0 00000000 1 005 0badcafe
eentry    1 1c000014 04003020 0 00 00000000 0 1 00c 1c008000 0 0000 0 0 1 0 00000000 2 00c 1c008000
crmd      1 1c000018 04000020 0 00 00000000 0 1 000 00000007 0 0000 0 0 1 0 00000000 2 000 00000007
adef      1 1c000020 02800000 0 00 00000000 0 0 000 00000000 1 0002 0 0 0 1 1c008000 2 005 00080000
rd_era    0 00000000 00000000 0 00 00000000 0 0 000 00000000 0 0000 0 0 0 0 00000000 2 006 1c000020
rd_badv   0 00000000 00000000 0 00 00000000 0 0 000 00000000 0 0000 0 0 0 0 00000000 2 007 1c000020
ertn      1 1c000024 06483800 0 00 00000000 1 0 000 00000000 0 0000 0 0 0 1 1c000020 2 000 00000007
ale_adem  1 1c000028 28800004 0 00 00001003 0 0 000 00000000 1 0600 0 0 0 1 1c008000 2 005 00090000
rd_badv2  0 00000000 00000000 0 00 00000000 0 0 000 00000000 0 0000 0 0 0 0 00000000 2 007 00001003
adem      1 1c00002c 28800004 0 00 80000010 0 0 000 00000000 1 0400 0 0 0 1 1c008000 2 005 00480000
tlbr_pme  1 1c000030 28800004 0 00 7fff6004 0 0 000 00000000 1 1800 0 0 0 1 1c008000 2 011 7fff6000
rd_estat  0 00000000 00000000 0 00 00000000 0 0 000 00000000 0 0000 0 0 0 0 00000000 2 005 003f0000
pif_ppi   1 1c00a044 02800000 0 00 00000000 0 0 000 00000000 1 0018 0 0 0 1 1c008000 2 011 1c00a000
rd_estat2 0 00000000 00000000 0 00 00000000 0 0 000 00000000 0 0000 0 0 0 0 00000000 2 005 00030000
sys_brk   1 1c000038 002b0000 0 00 00000000 0 0 000 00000000 1 0060 0 0 0 1 1c008000 2 006 1c000038
rd_badv3  0 00000000 00000000 0 00 00000000 0 0 000 00000000 0 0000 0 0 0 0 00000000 2 007 1c00a044
csr_ok    1 1c00003c 04001820 0 00 00000000 0 1 006 1c00f000 0 0000 0 0 1 0 00000000 2 006 1c00f000
csr_kill  1 1c000040 04001820 0 00 00000000 0 1 006 1c00f100 0 0000 0 1 0 0 00000000 2 006 1c00f000
